// File: verilog.f
issue_pkg.sv
issue_hazard_check.sv
issue_regfile.sv
issue_operand_stage.sv
issue_read_operands.sv
tb_clock_gen.sv
tb_issue_read_operands.sv

// File: Makefile
TB_TOP := tb_issue_read_operands

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module issue_read_operands
	verilator --lint-only --timing -f verilog.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP) | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// File: tb_issue_read_operands.sv
/*
 * testbench for the issue and read-operands stage
 * drives instructions, commits and hazard state, keeps a register model
 * and checks ack, strobes and operands with concurrent assertions
 */
`timescale 1ns/100ps

module tb_issue_read_operands import issue_pkg::*;;

    localparam int unsigned NR_PORTS    = 2;
    // rough stimulus length in cycles, the watchdog adds margin on top
    localparam int unsigned STIM_CYCLES = 90;

    logic clk;
    logic rst_n;
    int   seed = 32'h96ba2d21;

    // DUT inputs
    logic issue_valid, use_pc, use_imm, use_zimm, ex_valid, flush, flu_ready, lsu_ready;
    fu_t                                      issue_fu;
    fu_op_t                                   issue_op;
    logic [REG_ADDR_W-1:0]                    rs1, rs2, rd;
    logic [XLEN-1:0]                          imm, pc, rs1_data, rs2_data;
    logic                                     rs1_valid, rs2_valid;
    trans_id_t                                trans_id;
    fu_t  [NR_REGS-1:0]                       rd_clobber;
    logic [NR_PORTS-1:0][REG_ADDR_W-1:0]      commit_waddr;
    logic [NR_PORTS-1:0][XLEN-1:0]            commit_wdata;
    logic [NR_PORTS-1:0]                      commit_we;

    // DUT outputs
    logic                 issue_ack;
    logic [XLEN-1:0]      operand_a, operand_b, imm_q, pc_q;
    fu_t                  fu_q;
    fu_op_t               op_q;
    trans_id_t            trans_id_q;
    logic                 alu_v, branch_v, lsu_v, mult_v, csr_v;

    // state the tests set up for the next driven cycle
    fu_t  [NR_REGS-1:0]                  clob_next;
    logic [XLEN-1:0]                     rs1_data_next, rs2_data_next;
    logic                                rs1_valid_next, rs2_valid_next;
    logic                                flu_ready_next, lsu_ready_next, flush_next;
    logic [NR_PORTS-1:0][REG_ADDR_W-1:0] cw_addr_next;
    logic [NR_PORTS-1:0][XLEN-1:0]       cw_data_next;
    logic [NR_PORTS-1:0]                 cw_we_next;

    // register file model and expectations
    logic [XLEN-1:0] rf_model [NR_REGS];
    logic            exp_ack, exp_fire;
    logic [4:0]      exp_strobe;
    logic [XLEN-1:0] exp_a, exp_b, exp_imm, exp_pc;
    fu_t             exp_fu;
    fu_op_t          exp_op;
    trans_id_t       exp_tid;

    tb_clock_gen u_clock_gen (.clk_o(clk), .rst_no(rst_n));

    issue_read_operands #(.NR_COMMIT_PORTS(NR_PORTS)) u_dut (
        .clk_i(clk), .rst_uarch_ni(rst_n), .flush_i(flush),
        .issue_valid_i(issue_valid), .issue_fu_i(issue_fu), .issue_op_i(issue_op),
        .issue_rs1_i(rs1), .issue_rs2_i(rs2), .issue_rd_i(rd),
        .issue_imm_i(imm), .issue_pc_i(pc), .issue_use_pc_i(use_pc),
        .issue_use_imm_i(use_imm), .issue_use_zimm_i(use_zimm),
        .issue_trans_id_i(trans_id), .issue_ex_valid_i(ex_valid), .issue_ack_o(issue_ack),
        .rs1_data_i(rs1_data), .rs1_data_valid_i(rs1_valid),
        .rs2_data_i(rs2_data), .rs2_data_valid_i(rs2_valid), .rd_clobber_i(rd_clobber),
        .commit_waddr_i(commit_waddr), .commit_wdata_i(commit_wdata), .commit_we_i(commit_we),
        .flu_ready_i(flu_ready), .lsu_ready_i(lsu_ready),
        .operand_a_o(operand_a), .operand_b_o(operand_b), .imm_o(imm_q), .fu_o(fu_q),
        .operator_o(op_q), .trans_id_o(trans_id_q), .pc_o(pc_q),
        .alu_valid_o(alu_v), .branch_valid_o(branch_v), .lsu_valid_o(lsu_v),
        .mult_valid_o(mult_v), .csr_valid_o(csr_v)
    );

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic report_failure(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // strobe order is alu, branch, lsu, mult, csr
    function automatic logic [4:0] unit_strobe(input fu_t fu);
        case (fu)
            ALU:         return 5'b10000;
            CTRL_FLOW:   return 5'b01000;
            LOAD, STORE: return 5'b00100;
            MULT:        return 5'b00010;
            CSR:         return 5'b00001;
            default:     return 5'b00000;
        endcase
    endfunction

    // one cycle of stimulus, sel is {use_pc, use_imm, use_zimm}
    task automatic drive_cycle(input logic vld, input fu_t fu, input fu_op_t op,
                               input logic [4:0] a_reg, input logic [4:0] b_reg,
                               input logic [4:0] d_reg, input logic [2:0] sel,
                               input logic ex, input logic ack);
        logic [XLEN-1:0] new_imm;
        logic [XLEN-1:0] new_pc;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic            fire;
        new_imm = {$random(seed), $random(seed)};
        new_pc  = {$random(seed), $random(seed)};
        // operand a: zimm, then pc, then forwarded, then register file
        if (sel[0])
            a = {{(XLEN-REG_ADDR_W){1'b0}}, a_reg};
        else if (sel[2])
            a = new_pc;
        else if (clob_next[a_reg] != NONE)
            a = rs1_data_next;
        else
            a = rf_model[a_reg];
        // operand b: immediate unless store or branch
        if (sel[1] && fu != STORE && fu != CTRL_FLOW)
            b = new_imm;
        else if (clob_next[b_reg] != NONE)
            b = rs2_data_next;
        else
            b = rf_model[b_reg];
        fire = vld && ack && !ex;
        @(posedge clk);
        issue_valid <= vld;
        issue_fu    <= fu;
        issue_op    <= op;
        rs1         <= a_reg;
        rs2         <= b_reg;
        rd          <= d_reg;
        {use_pc, use_imm, use_zimm} <= sel;
        ex_valid    <= ex;
        imm         <= new_imm;
        pc          <= new_pc;
        trans_id    <= trans_id + 1'b1;
        rd_clobber  <= clob_next;
        rs1_data    <= rs1_data_next;
        rs2_data    <= rs2_data_next;
        rs1_valid   <= rs1_valid_next;
        rs2_valid   <= rs2_valid_next;
        flu_ready   <= flu_ready_next;
        lsu_ready   <= lsu_ready_next;
        flush       <= flush_next;
        commit_waddr <= cw_addr_next;
        commit_wdata <= cw_data_next;
        commit_we    <= cw_we_next;
        exp_ack     <= vld && ack;
        exp_fire    <= fire;
        exp_strobe  <= (fire && !flush_next) ? unit_strobe(fu) : 5'b0;
        exp_a       <= a;
        exp_b       <= b;
        exp_imm     <= new_imm;
        exp_pc      <= new_pc;
        exp_fu      <= fu;
        exp_op      <= op;
        exp_tid     <= trans_id + 1'b1;
        // commits land in the model after this cycle's reads, later port wins
        for (int p = 0; p < NR_PORTS; p++) begin
            if (cw_we_next[p] && cw_addr_next[p] != '0)
                rf_model[cw_addr_next[p]] = cw_data_next[p];
        end
        cw_we_next = '0;
        flush_next = 1'b0;
    endtask

    task automatic idle();
        drive_cycle(1'b0, NONE, ADD, 5'd0, 5'd0, 5'd0, 3'b000, 1'b0, 1'b0);
    endtask

    task automatic commit(input int port, input logic [4:0] addr);
        cw_addr_next[port] = addr;
        cw_data_next[port] = {$random(seed), $random(seed)};
        cw_we_next[port]   = 1'b1;
    endtask

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    a_reset: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |->
        ({alu_v, branch_v, lsu_v, mult_v, csr_v} == 5'b0 && fu_q == NONE))
        else report_failure("strobes or fu_o not idle around reset");

    a_ack: assert property (@(posedge clk) disable iff (!rst_n) issue_ack == exp_ack)
        else report_failure("issue_ack_o differs from expected");

    a_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        {alu_v, branch_v, lsu_v, mult_v, csr_v} == $past(exp_strobe))
        else report_failure("unit strobes differ from expected");

    a_operands: assert property (@(posedge clk) disable iff (!rst_n) $past(exp_fire) |->
        (operand_a == $past(exp_a) && operand_b == $past(exp_b)
         && imm_q == $past(exp_imm) && pc_q == $past(exp_pc)
         && fu_q == $past(exp_fu) && op_q == $past(exp_op)
         && trans_id_q == $past(exp_tid)))
        else report_failure("issued operands differ from expected");

    initial begin
        repeat (STIM_CYCLES + 200) @(posedge clk);
        $display("watchdog expired before the stimulus finished");
        $display("CHECKS FAILED");
        $fatal(1);
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        logic [4:0] r;
        issue_valid = 1'b0;
        issue_fu = NONE;
        issue_op = ADD;
        rs1 = '0;
        rs2 = '0;
        rd = '0;
        imm = '0;
        pc = '0;
        use_pc = 1'b0;
        use_imm = 1'b0;
        use_zimm = 1'b0;
        trans_id = '0;
        ex_valid = 1'b0;
        flush = 1'b0;
        rd_clobber = '0;
        rs1_data = '0;
        rs2_data = '0;
        rs1_valid = 1'b0;
        rs2_valid = 1'b0;
        commit_waddr = '0;
        commit_wdata = '0;
        commit_we = '0;
        flu_ready = 1'b1;
        lsu_ready = 1'b1;
        clob_next = '0;
        rs1_data_next = '0;
        rs2_data_next = '0;
        rs1_valid_next = 1'b0;
        rs2_valid_next = 1'b0;
        flu_ready_next = 1'b1;
        lsu_ready_next = 1'b1;
        flush_next = 1'b0;
        cw_addr_next = '0;
        cw_data_next = '0;
        cw_we_next = '0;
        exp_ack = 1'b0;
        exp_fire = 1'b0;
        exp_strobe = '0;
        exp_a = '0;
        exp_b = '0;
        exp_imm = '0;
        exp_pc = '0;
        exp_fu = NONE;
        exp_op = ADD;
        exp_tid = '0;
        for (int i = 0; i < NR_REGS; i++) begin
            rf_model[i] = '0;
        end
        @(posedge rst_n);
        idle();

        // clean issue after commits, x0 commit must not stick
        for (int i = 0; i < 8; i++) begin
            r = 5'($random(seed));
            commit(0, r);
            commit(1, 5'd0);
            idle();
            drive_cycle(1'b1, ALU, ADD, r, 5'($random(seed)), 5'd9, 3'b000, 1'b0, 1'b1);
        end
        drive_cycle(1'b1, CTRL_FLOW, JALR, 5'd0, 5'd0, 5'd1, 3'b000, 1'b0, 1'b1);

        // forwarding from a non-csr unit, then stalls
        clob_next[5] = LOAD;
        clob_next[6] = ALU;
        rs1_data_next = {$random(seed), $random(seed)};
        rs2_data_next = {$random(seed), $random(seed)};
        rs1_valid_next = 1'b1;
        rs2_valid_next = 1'b1;
        drive_cycle(1'b1, ALU, ADD, 5'd5, 5'd6, 5'd7, 3'b000, 1'b0, 1'b1);
        rs2_valid_next = 1'b0;
        drive_cycle(1'b1, ALU, ADD, 5'd5, 5'd6, 5'd7, 3'b000, 1'b0, 1'b0);
        rs2_valid_next = 1'b1;
        clob_next[5] = CSR;
        drive_cycle(1'b1, ALU, SUB, 5'd5, 5'd6, 5'd7, 3'b000, 1'b0, 1'b0);
        clob_next = '0;

        // WAW on rd, released by a same-cycle commit
        clob_next[8] = ALU;
        drive_cycle(1'b1, ALU, ADD, 5'd1, 5'd2, 5'd8, 3'b000, 1'b0, 1'b0);
        commit(1, 5'd8);
        drive_cycle(1'b1, ALU, ADD, 5'd1, 5'd2, 5'd8, 3'b000, 1'b0, 1'b1);
        // excepted and unit-less entries pass anyway, no strobe
        drive_cycle(1'b1, ALU, ADD, 5'd1, 5'd2, 5'd8, 3'b000, 1'b1, 1'b1);
        drive_cycle(1'b1, NONE, ADD, 5'd1, 5'd2, 5'd8, 3'b000, 1'b0, 1'b1);
        clob_next = '0;

        // unit back-pressure
        flu_ready_next = 1'b0;
        drive_cycle(1'b1, MULT, MUL, 5'd3, 5'd4, 5'd10, 3'b000, 1'b0, 1'b0);
        drive_cycle(1'b1, LOAD, LD, 5'd3, 5'd4, 5'd10, 3'b010, 1'b0, 1'b1);
        flu_ready_next = 1'b1;
        lsu_ready_next = 1'b0;
        drive_cycle(1'b1, STORE, SD, 5'd3, 5'd4, 5'd0, 3'b010, 1'b0, 1'b0);
        lsu_ready_next = 1'b1;

        // mult contention
        drive_cycle(1'b1, MULT, MUL, 5'd3, 5'd4, 5'd11, 3'b000, 1'b0, 1'b1);
        drive_cycle(1'b1, MULT, MUL, 5'd4, 5'd3, 5'd12, 3'b000, 1'b0, 1'b1);
        drive_cycle(1'b1, ALU, ADD, 5'd4, 5'd3, 5'd13, 3'b000, 1'b0, 1'b0);
        drive_cycle(1'b1, ALU, ADD, 5'd4, 5'd3, 5'd13, 3'b000, 1'b0, 1'b1);

        // flush in the accepted cycle, a flushed mult blocks nothing
        flush_next = 1'b1;
        drive_cycle(1'b1, MULT, MUL, 5'd3, 5'd4, 5'd14, 3'b000, 1'b0, 1'b1);
        drive_cycle(1'b1, CSR, CSR_READ, 5'd3, 5'd0, 5'd15, 3'b000, 1'b0, 1'b1);

        // operand selection
        drive_cycle(1'b1, CSR, CSR_READ, 5'd27, 5'd0, 5'd15, 3'b001, 1'b0, 1'b1);
        drive_cycle(1'b1, ALU, ADD, 5'd3, 5'd4, 5'd16, 3'b100, 1'b0, 1'b1);
        drive_cycle(1'b1, ALU, ADD, 5'd3, 5'd4, 5'd16, 3'b010, 1'b0, 1'b1);
        drive_cycle(1'b1, STORE, SD, 5'd3, 5'd4, 5'd0, 3'b010, 1'b0, 1'b1);
        drive_cycle(1'b1, CTRL_FLOW, JALR, 5'd3, 5'd4, 5'd1, 3'b110, 1'b0, 1'b1);
        drive_cycle(1'b1, LOAD, LD, 5'd3, 5'd4, 5'd17, 3'b010, 1'b0, 1'b1);
        idle();
        idle();
        // let the checks on the last rising edge complete
        @(negedge clk);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: tb_clock_gen.sv
/*
 * testbench clock and reset
 * 10 ns clock, active-low reset held for the first 10 cycles
 */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // release on a rising edge so the DUT sees a clean first cycle
    initial begin
        rst_no = 1'b0;
        repeat (10) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

// File: issue_read_operands.sv
/*
 * issue and read-operands stage
 * hazard check, integer register file and issue register
 */
`timescale 1ns/100ps

module issue_read_operands import issue_pkg::*; #(
    parameter int unsigned NR_COMMIT_PORTS = 2
)(
    input  logic                                         clk_i,
    input  logic                                         rst_uarch_ni,
    input  logic                                         flush_i,
    // instruction from the scoreboard
    input  logic                                         issue_valid_i,
    input  fu_t                                          issue_fu_i,
    input  fu_op_t                                       issue_op_i,
    input  logic [REG_ADDR_W-1:0]                        issue_rs1_i,
    input  logic [REG_ADDR_W-1:0]                        issue_rs2_i,
    input  logic [REG_ADDR_W-1:0]                        issue_rd_i,
    input  logic [XLEN-1:0]                              issue_imm_i,
    input  logic [XLEN-1:0]                              issue_pc_i,
    input  logic                                         issue_use_pc_i,
    input  logic                                         issue_use_imm_i,
    input  logic                                         issue_use_zimm_i,
    input  trans_id_t                                    issue_trans_id_i,
    input  logic                                         issue_ex_valid_i,
    output logic                                         issue_ack_o,
    // scoreboard lookup
    input  logic [XLEN-1:0]                              rs1_data_i,
    input  logic                                         rs1_data_valid_i,
    input  logic [XLEN-1:0]                              rs2_data_i,
    input  logic                                         rs2_data_valid_i,
    input  fu_t  [NR_REGS-1:0]                           rd_clobber_i,
    // commit ports
    input  logic [NR_COMMIT_PORTS-1:0][REG_ADDR_W-1:0]   commit_waddr_i,
    input  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]         commit_wdata_i,
    input  logic [NR_COMMIT_PORTS-1:0]                   commit_we_i,
    // unit readiness
    input  logic                                         flu_ready_i,
    input  logic                                         lsu_ready_i,
    // towards the units
    output logic [XLEN-1:0]                              operand_a_o,
    output logic [XLEN-1:0]                              operand_b_o,
    output logic [XLEN-1:0]                              imm_o,
    output fu_t                                          fu_o,
    output fu_op_t                                       operator_o,
    output trans_id_t                                    trans_id_o,
    output logic [XLEN-1:0]                              pc_o,
    output logic                                         alu_valid_o,
    output logic                                         branch_valid_o,
    output logic                                         lsu_valid_o,
    output logic                                         mult_valid_o,
    output logic                                         csr_valid_o
);

    logic            fwd_rs1;
    logic            fwd_rs2;
    logic            issue_fire;
    logic [XLEN-1:0] rf_rdata_a;
    logic [XLEN-1:0] rf_rdata_b;

    // --------------------------------------------------
    // hazard check, mult strobe comes back as contention
    // --------------------------------------------------
    issue_hazard_check #(
        .NR_COMMIT_PORTS  ( NR_COMMIT_PORTS  )
    ) u_hazard_check (
        .issue_valid_i    ( issue_valid_i    ),
        .issue_fu_i       ( issue_fu_i       ),
        .issue_rs1_i      ( issue_rs1_i      ),
        .issue_rs2_i      ( issue_rs2_i      ),
        .issue_rd_i       ( issue_rd_i       ),
        .issue_use_zimm_i ( issue_use_zimm_i ),
        .issue_ex_valid_i ( issue_ex_valid_i ),
        .rs1_data_valid_i ( rs1_data_valid_i ),
        .rs2_data_valid_i ( rs2_data_valid_i ),
        .rd_clobber_i     ( rd_clobber_i     ),
        .commit_waddr_i   ( commit_waddr_i   ),
        .commit_we_i      ( commit_we_i      ),
        .flu_ready_i      ( flu_ready_i      ),
        .lsu_ready_i      ( lsu_ready_i      ),
        .mult_issued_i    ( mult_valid_o     ),
        .fwd_rs1_o        ( fwd_rs1          ),
        .fwd_rs2_o        ( fwd_rs2          ),
        .issue_ack_o      ( issue_ack_o      ),
        .issue_fire_o     ( issue_fire       )
    );

    issue_regfile #(
        .NR_COMMIT_PORTS ( NR_COMMIT_PORTS )
    ) u_regfile (
        .clk_i           ( clk_i           ),
        .rst_uarch_ni    ( rst_uarch_ni    ),
        .raddr_a_i       ( issue_rs1_i     ),
        .raddr_b_i       ( issue_rs2_i     ),
        .waddr_i         ( commit_waddr_i  ),
        .wdata_i         ( commit_wdata_i  ),
        .we_i            ( commit_we_i     ),
        .rdata_a_o       ( rf_rdata_a      ),
        .rdata_b_o       ( rf_rdata_b      )
    );

    issue_operand_stage u_operand_stage (
        .clk_i            ( clk_i            ),
        .rst_uarch_ni     ( rst_uarch_ni     ),
        .flush_i          ( flush_i          ),
        .issue_fire_i     ( issue_fire       ),
        .issue_fu_i       ( issue_fu_i       ),
        .issue_op_i       ( issue_op_i       ),
        .issue_rs1_i      ( issue_rs1_i      ),
        .issue_imm_i      ( issue_imm_i      ),
        .issue_pc_i       ( issue_pc_i       ),
        .issue_use_pc_i   ( issue_use_pc_i   ),
        .issue_use_imm_i  ( issue_use_imm_i  ),
        .issue_use_zimm_i ( issue_use_zimm_i ),
        .issue_trans_id_i ( issue_trans_id_i ),
        .fwd_rs1_i        ( fwd_rs1          ),
        .fwd_rs2_i        ( fwd_rs2          ),
        .rs1_data_i       ( rs1_data_i       ),
        .rs2_data_i       ( rs2_data_i       ),
        .rf_rdata_a_i     ( rf_rdata_a       ),
        .rf_rdata_b_i     ( rf_rdata_b       ),
        .operand_a_o      ( operand_a_o      ),
        .operand_b_o      ( operand_b_o      ),
        .imm_o            ( imm_o            ),
        .fu_o             ( fu_o             ),
        .operator_o       ( operator_o       ),
        .trans_id_o       ( trans_id_o       ),
        .pc_o             ( pc_o             ),
        .alu_valid_o      ( alu_valid_o      ),
        .branch_valid_o   ( branch_valid_o   ),
        .lsu_valid_o      ( lsu_valid_o      ),
        .mult_valid_o     ( mult_valid_o     ),
        .csr_valid_o      ( csr_valid_o      )
    );

endmodule

// File: issue_operand_stage.sv
/*
 * operand select and issue register
 * muxes zimm, pc, forwarded data, regfile and immediate into the two
 * operands, registers them and pulses one valid strobe per unit
 */
`timescale 1ns/100ps

module issue_operand_stage import issue_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_uarch_ni,
    input  logic                   flush_i,
    input  logic                   issue_fire_i,
    input  fu_t                    issue_fu_i,
    input  fu_op_t                 issue_op_i,
    input  logic [REG_ADDR_W-1:0]  issue_rs1_i,
    input  logic [XLEN-1:0]        issue_imm_i,
    input  logic [XLEN-1:0]        issue_pc_i,
    input  logic                   issue_use_pc_i,
    input  logic                   issue_use_imm_i,
    input  logic                   issue_use_zimm_i,
    input  trans_id_t              issue_trans_id_i,
    input  logic                   fwd_rs1_i,
    input  logic                   fwd_rs2_i,
    input  logic [XLEN-1:0]        rs1_data_i,
    input  logic [XLEN-1:0]        rs2_data_i,
    input  logic [XLEN-1:0]        rf_rdata_a_i,
    input  logic [XLEN-1:0]        rf_rdata_b_i,
    output logic [XLEN-1:0]        operand_a_o,
    output logic [XLEN-1:0]        operand_b_o,
    output logic [XLEN-1:0]        imm_o,
    output fu_t                    fu_o,
    output fu_op_t                 operator_o,
    output trans_id_t              trans_id_o,
    output logic [XLEN-1:0]        pc_o,
    output logic                   alu_valid_o,
    output logic                   branch_valid_o,
    output logic                   lsu_valid_o,
    output logic                   mult_valid_o,
    output logic                   csr_valid_o
);

    logic [XLEN-1:0] operand_a_d;
    logic [XLEN-1:0] operand_b_d;

    // --------------------------------------------------
    // operand mux
    // --------------------------------------------------
    always_comb begin
        // lowest priority first, later ifs override
        operand_a_d = fwd_rs1_i ? rs1_data_i : rf_rdata_a_i;
        operand_b_d = fwd_rs2_i ? rs2_data_i : rf_rdata_b_i;
        if (issue_use_pc_i) begin
            operand_a_d = issue_pc_i;
        end
        // csr immediate sits in the rs1 field
        if (issue_use_zimm_i) begin
            operand_a_d = {{(XLEN-REG_ADDR_W){1'b0}}, issue_rs1_i};
        end
        // stores and branches still need rs2, their imm goes out on imm_o
        if (issue_use_imm_i && issue_fu_i != STORE && issue_fu_i != CTRL_FLOW) begin
            operand_b_d = issue_imm_i;
        end
    end

    // --------------------------------------------------
    // issue register
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
        if (!rst_uarch_ni) begin
            operand_a_o <= '0;
            operand_b_o <= '0;
            imm_o       <= '0;
            fu_o        <= NONE;
            operator_o  <= ADD;
            trans_id_o  <= '0;
            pc_o        <= '0;
        end else begin
            operand_a_o <= operand_a_d;
            operand_b_o <= operand_b_d;
            imm_o       <= issue_imm_i;
            fu_o        <= issue_fu_i;
            operator_o  <= issue_op_i;
            trans_id_o  <= issue_trans_id_i;
            pc_o        <= issue_pc_i;
        end
    end

    // one cycle strobe towards the selected unit
    always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
        if (!rst_uarch_ni) begin
            alu_valid_o    <= 1'b0;
            branch_valid_o <= 1'b0;
            lsu_valid_o    <= 1'b0;
            mult_valid_o   <= 1'b0;
            csr_valid_o    <= 1'b0;
        end else begin
            alu_valid_o    <= issue_fire_i && !flush_i && issue_fu_i == ALU;
            branch_valid_o <= issue_fire_i && !flush_i && issue_fu_i == CTRL_FLOW;
            lsu_valid_o    <= issue_fire_i && !flush_i
                              && (issue_fu_i == LOAD || issue_fu_i == STORE);
            mult_valid_o   <= issue_fire_i && !flush_i && issue_fu_i == MULT;
            csr_valid_o    <= issue_fire_i && !flush_i && issue_fu_i == CSR;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_uarch_ni)
        $onehot0({alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o}))
        else $error("more than one unit strobe");

    assert property (@(posedge clk_i) disable iff (!rst_uarch_ni)
        branch_valid_o |-> !$isunknown({operand_a_o, operand_b_o}))
        else $error("unknown operand on branch issue");

endmodule

// File: issue_regfile.sv
/*
 * integer register file
 * 31 flops plus hard-wired x0, two combinational read ports and
 * NR_COMMIT_PORTS write ports, highest port wins on collision
 */
`timescale 1ns/100ps

module issue_regfile import issue_pkg::*; #(
    parameter int unsigned NR_COMMIT_PORTS = 2
)(
    input  logic                                         clk_i,
    input  logic                                         rst_uarch_ni,
    input  logic [REG_ADDR_W-1:0]                        raddr_a_i,
    input  logic [REG_ADDR_W-1:0]                        raddr_b_i,
    input  logic [NR_COMMIT_PORTS-1:0][REG_ADDR_W-1:0]   waddr_i,
    input  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]         wdata_i,
    input  logic [NR_COMMIT_PORTS-1:0]                   we_i,
    output logic [XLEN-1:0]                              rdata_a_o,
    output logic [XLEN-1:0]                              rdata_b_o
);

    // x0 has no storage
    logic [XLEN-1:0] mem_q [NR_REGS-1:1];

    // --------------------------------------------------
    // write ports
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
        if (!rst_uarch_ni) begin
            for (int unsigned r = 1; r < NR_REGS; r++) begin
                mem_q[r] <= '0;
            end
        end else begin
            // loop order gives the later port priority
            for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
                if (we_i[i] && waddr_i[i] != '0) begin
                    mem_q[waddr_i[i]] <= wdata_i[i];
                end
            end
        end
    end

    // --------------------------------------------------
    // read ports
    // --------------------------------------------------
    // no bypass, a commit shows up one cycle later
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : mem_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : mem_q[raddr_b_i];

    // the highest commit port always lands in storage
    assert property (@(posedge clk_i) disable iff (!rst_uarch_ni)
        we_i[NR_COMMIT_PORTS-1] && waddr_i[NR_COMMIT_PORTS-1] != '0 |=>
            mem_q[$past(waddr_i[NR_COMMIT_PORTS-1])] == $past(wdata_i[NR_COMMIT_PORTS-1]))
        else $error("highest commit port write lost");

endmodule

// File: issue_hazard_check.sv
/*
 * issue hazard check
 * RAW forwarding/stall decision per source operand, WAW check on rd,
 * unit readiness and mult contention; drives the same-cycle issue ack
 */
`timescale 1ns/100ps

module issue_hazard_check import issue_pkg::*; #(
    parameter int unsigned NR_COMMIT_PORTS = 2
)(
    input  logic                                         issue_valid_i,
    input  fu_t                                          issue_fu_i,
    input  logic [REG_ADDR_W-1:0]                        issue_rs1_i,
    input  logic [REG_ADDR_W-1:0]                        issue_rs2_i,
    input  logic [REG_ADDR_W-1:0]                        issue_rd_i,
    input  logic                                         issue_use_zimm_i,
    input  logic                                         issue_ex_valid_i,
    input  logic                                         rs1_data_valid_i,
    input  logic                                         rs2_data_valid_i,
    input  fu_t  [NR_REGS-1:0]                           rd_clobber_i,
    input  logic [NR_COMMIT_PORTS-1:0][REG_ADDR_W-1:0]   commit_waddr_i,
    input  logic [NR_COMMIT_PORTS-1:0]                   commit_we_i,
    input  logic                                         flu_ready_i,
    input  logic                                         lsu_ready_i,
    input  logic                                         mult_issued_i,
    output logic                                         fwd_rs1_o,
    output logic                                         fwd_rs2_o,
    output logic                                         issue_ack_o,
    output logic                                         issue_fire_o
);

    logic stall;
    logic fu_busy;
    logic rd_free;
    logic mult_block;

    // --------------------------------------------------
    // unit readiness
    // --------------------------------------------------
    always_comb begin
        unique case (issue_fu_i)
            ALU, CTRL_FLOW, CSR, MULT: fu_busy = ~flu_ready_i;
            LOAD, STORE:               fu_busy = ~lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // RAW check on rs1/rs2
    // --------------------------------------------------
    always_comb begin
        stall     = 1'b0;
        fwd_rs1_o = 1'b0;
        fwd_rs2_o = 1'b0;
        // zimm puts an immediate in the rs1 field, nothing to wait for
        if (!issue_use_zimm_i && rd_clobber_i[issue_rs1_i] != NONE) begin
            // csr results only reach us through the register file
            if (rs1_data_valid_i && rd_clobber_i[issue_rs1_i] != CSR) begin
                fwd_rs1_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (rd_clobber_i[issue_rs2_i] != NONE) begin
            if (rs2_data_valid_i && rd_clobber_i[issue_rs2_i] != CSR) begin
                fwd_rs2_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // WAW check on rd
    // --------------------------------------------------
    // a commit writing rd this cycle frees the destination
    always_comb begin
        rd_free = (rd_clobber_i[issue_rd_i] == NONE);
        for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
            if (commit_we_i[i] && commit_waddr_i[i] == issue_rd_i) begin
                rd_free = 1'b1;
            end
        end
    end

    // mult results share the fixed latency writeback with everything else
    assign mult_block = mult_issued_i && (issue_fu_i != MULT);

    always_comb begin
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!stall && !fu_busy && rd_free) begin
                issue_ack_o = 1'b1;
            end
            // excepted or unit-less entries just retire through the scoreboard
            if (issue_ex_valid_i || issue_fu_i == NONE) begin
                issue_ack_o = 1'b1;
            end
        end
        if (mult_block) begin
            issue_ack_o = 1'b0;
        end
    end

    assign issue_fire_o = issue_valid_i && issue_ack_o && !issue_ex_valid_i;

endmodule

// File: issue_pkg.sv
/*
 * issue stage package
 * widths, functional-unit and operator encodings and the
 * scoreboard transaction id shared by the issue/read-operands stage
 */
package issue_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    // integer datapath width
    localparam int unsigned XLEN       = 64;
    // architectural register address
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned NR_REGS    = 32;
    // scoreboard entry index
    localparam int unsigned TRANS_ID_W = 3;

    typedef logic [TRANS_ID_W-1:0] trans_id_t;

    // --------------------------------------------------
    // functional units
    // --------------------------------------------------
    // NONE must stay zero, the clobber table uses it as "no pending write"
    typedef enum logic [2:0] {
        NONE      = 3'd0,
        LOAD      = 3'd1,
        STORE     = 3'd2,
        ALU       = 3'd3,
        CTRL_FLOW = 3'd4,
        MULT      = 3'd5,
        CSR       = 3'd6
    } fu_t;

    // --------------------------------------------------
    // operators
    // --------------------------------------------------
    // only a subset is named, the stage forwards the code untouched
    typedef enum logic [6:0] {
        ADD      = 7'd0,
        SUB      = 7'd1,
        MUL      = 7'd2,
        LD       = 7'd3,
        SD       = 7'd4,
        JALR     = 7'd5,
        CSR_READ = 7'd6
    } fu_op_t;

endpackage
